// File: hdl/ps2Pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// ps2 receive path shared types
////////////////////////////////////////////////////////////

package ps2Pkg;

    // one frame on the wire
    localparam int frameBits = 11; // start, 8 data, parity, stop

    typedef logic [7:0] scanCodeT; // data byte, lsb sent first

    // frame as the fields sit after eleven right shifts
    typedef struct packed {
        logic     stopBit;   // last bit in, ends on top
        logic     parityBit; // odd parity over scanCode
        scanCodeT scanCode;
        logic     startBit;  // first bit in, ends at bit 0
    } frameFieldsT;

    // raw shift word and its field view
    typedef union packed {
        logic [frameBits-1:0] raw;
        frameFieldsT          fields;
    } ps2FrameU;

    // receive fsm, same encoding as the old reader
    typedef enum logic [2:0] {
        idle      = 3'd0,
        saveBit   = 3'd1,
        clockLow  = 3'd2,
        clockHigh = 3'd3,
        wordDone  = 3'd4,
        delay     = 3'd5
    } rxStateT;

    typedef logic [3:0] bitCountT; // 0 .. 11, held at 11

endpackage

`default_nettype wire

// File: hdl/ps2BitTimer.sv
`timescale 1ns/1ns
`default_nettype none

module ps2BitTimer #(
    parameter int sampleDelay  = 130,
    parameter int frameTimeout = 3700
) (
    input  wire  ck,
    input  wire  reset,
    input  wire  clearDelay,   // level, holds delay count at 0
    input  wire  clearTimeout, // level, holds timeout count at 0
    output logic delayHit,
    output logic timeoutHit
);

    // index 0 settle delay, index 1 frame timeout
    localparam logic [1:0][11:0] limitTab = {12'(frameTimeout), 12'(sampleDelay)};

    wire [1:0] clearVec;
    wire [1:0] hitVec;

    assign clearVec = {clearTimeout, clearDelay};

    ////////////////////////////////////////////////////////////
    // saturating counters
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin : gCounter
        logic [11:0] count;

        always_ff @(posedge ck or posedge reset) begin
            if (reset) begin
                count <= '0;
            end else if (clearVec[i]) begin
                count <= '0;
            end else if (count != limitTab[i]) begin
                count <= count + 12'd1; // stop at the limit
            end
        end

        // stays high until cleared
        assign hitVec[i] = (count == limitTab[i]);
    end

    assign delayHit   = hitVec[0];
    assign timeoutHit = hitVec[1]; // frame abandoned

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // settle delay lands exactly sampleDelay cycles after
    // clearDelay is released, control samples on this hit
    property pDelayLength;
        @(posedge ck) disable iff (reset)
            $rose(delayHit) |->
                $past(clearDelay, sampleDelay + 1) && !$past(clearDelay, sampleDelay);
    endproperty
    assert property (pDelayLength)
        else $error("delayHit not sampleDelay cycles after clearDelay fell");

endmodule

`default_nettype wire

// File: hdl/ps2FrameShifter.sv
`timescale 1ns/1ns
`default_nettype none

module ps2FrameShifter (
    input  wire               ck,
    input  wire               reset,
    input  wire               dataSync,   // synchronized ps2 data
    input  wire               shiftBit,   // one-cycle sample strobe
    input  wire               clearCount, // level, count back to 0
    output ps2Pkg::ps2FrameU  frame,
    output ps2Pkg::bitCountT  bitCount
);
    import ps2Pkg::*;

    localparam bitCountT fullCount = bitCountT'(frameBits); // 11

    ////////////////////////////////////////////////////////////
    // frame shift register
    ////////////////////////////////////////////////////////////

    // new bit enters on top and moves down, so after eleven
    // shifts the start bit sits at bit 0 and stop on top
    always_ff @(posedge ck) begin
        if (shiftBit) begin
            frame.raw <= {dataSync, frame.raw[frameBits-1:1]};
        end
    end
    // held between frames, scanCode stays valid until the next sample

    ////////////////////////////////////////////////////////////
    // bit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            bitCount <= '0;
        end else if (clearCount) begin
            bitCount <= '0; // idle or wordDone
        end else if (shiftBit && bitCount != fullCount) begin
            bitCount <= bitCount + bitCountT'(1); // no wrap past 11
        end
    end

    // field decode is the fields view of the union,
    // parity and stop are carried but not checked

endmodule

`default_nettype wire

// File: hdl/ps2RxControl.sv
`timescale 1ns/1ns
`default_nettype none

module ps2RxControl (
    input  wire               ck,
    input  wire               reset,
    input  wire               ps2Clk,
    input  wire               ps2Data,
    input  wire               delayHit,   // settle delay elapsed
    input  wire               timeoutHit, // clock idle too long
    input  ps2Pkg::bitCountT  bitCount,
    output logic              dataSync,
    output logic              shiftBit,
    output logic              clearCount,
    output logic              clearDelay,
    output logic              clearTimeout,
    output logic              wordReady
);
    import ps2Pkg::*;

    logic [1:0] clkPipe;  // two flops per line
    logic [1:0] dataPipe;
    logic       clkSync;
    rxStateT    state;
    rxStateT    stateNext;

    ////////////////////////////////////////////////////////////
    // line synchronizers
    ////////////////////////////////////////////////////////////

    // both lines idle high, so reset to 1
    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            clkPipe  <= 2'b11;
            dataPipe <= 2'b11;
        end else begin
            clkPipe  <= {clkPipe[0], ps2Clk};
            dataPipe <= {dataPipe[0], ps2Data};
        end
    end

    assign clkSync  = clkPipe[1];  // two ck late
    assign dataSync = dataPipe[1]; // bit fed to the shifter

    ////////////////////////////////////////////////////////////
    // receive fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state; // hold by default
        case (state)
            idle: begin
                if (!clkSync && !dataSync) begin // start bit seen
                    stateNext = delay;
                end
            end
            delay: begin
                if (delayHit) begin // line has settled
                    stateNext = saveBit;
                end
            end
            saveBit: stateNext = clockLow; // single cycle
            clockLow: begin
                if (clkSync) begin
                    stateNext = clockHigh;
                end
            end
            clockHigh: begin
                // timeout wins, then frame end, then next falling edge
                if (timeoutHit) begin
                    stateNext = idle;
                end else if (bitCount == bitCountT'(frameBits)) begin
                    stateNext = wordDone;
                end else if (!clkSync) begin
                    stateNext = delay;
                end
            end
            wordDone: stateNext = idle;
            default:  stateNext = idle;
        endcase
    end

    // moore outputs
    always_comb begin
        case (state)
            idle:      {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b01110;
            delay:     {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b00000;
            saveBit:   {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b10110;
            clockLow:  {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b00110;
            clockHigh: {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b00100;
            wordDone:  {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b01111;
            default:   {shiftBit, clearCount, clearDelay, clearTimeout, wordReady} = 5'b01110;
        endcase
    end
    // timeout counts through delay and clockHigh of one bit,
    // restarted on every saveBit

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // frame pulse is a single cycle, idle always follows
    property pReadySingle;
        @(posedge ck) disable iff (reset)
            wordReady |=> !wordReady;
    endproperty
    assert property (pReadySingle)
        else $error("wordReady high on two consecutive cycles");

    // shifter count must leave room for the bit being shifted
    property pNoShiftWhenFull;
        @(posedge ck) disable iff (reset)
            shiftBit |-> (bitCount != bitCountT'(frameBits));
    endproperty
    assert property (pNoShiftWhenFull)
        else $error("shiftBit with bitCount already at frame end");

endmodule

`default_nettype wire

// File: hdl/ps2Receiver.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////
// ps2 host-side receiver, top level
////////////////////////////////////////////////////////////

module ps2Receiver #(
    parameter int sampleDelay  = 130,  // ck cycles, falling edge to sample
    parameter int frameTimeout = 3700  // ck cycles of idle clock to drop a frame
) (
    input  wire              ck,
    input  wire              reset,
    input  wire              ps2Clk,    // raw line from the device
    input  wire              ps2Data,   // raw line from the device
    output wire              wordReady, // one ck pulse per full frame
    output ps2Pkg::scanCodeT scanCode
);
    import ps2Pkg::*;

    wire      dataSync;
    wire      shiftBit;
    wire      clearCount;
    wire      clearDelay;
    wire      clearTimeout;
    wire      delayHit;
    wire      timeoutHit;
    bitCountT bitCount;
    ps2FrameU frame;

    ps2RxControl control_i (
        .ck(ck), .reset(reset),
        .ps2Clk(ps2Clk), .ps2Data(ps2Data),
        .delayHit(delayHit), .timeoutHit(timeoutHit), .bitCount(bitCount),
        .dataSync(dataSync), .shiftBit(shiftBit), .clearCount(clearCount),
        .clearDelay(clearDelay), .clearTimeout(clearTimeout),
        .wordReady(wordReady)
    );

    ps2BitTimer #(
        .sampleDelay(sampleDelay),
        .frameTimeout(frameTimeout)
    ) timer_i (
        .ck(ck), .reset(reset),
        .clearDelay(clearDelay), .clearTimeout(clearTimeout),
        .delayHit(delayHit), .timeoutHit(timeoutHit)
    );

    ps2FrameShifter shifter_i (
        .ck(ck), .reset(reset),
        .dataSync(dataSync), .shiftBit(shiftBit), .clearCount(clearCount),
        .frame(frame), .bitCount(bitCount)
    );

    assign scanCode = frame.fields.scanCode; // data byte of the field view

endmodule

`default_nettype wire

// File: bench/ps2ReceiverTb.sv
`timescale 1ns/1ns
`default_nettype none

module ps2ReceiverTb;
    import ps2Pkg::*;

    localparam int sampleDelay  = 6;  // short settle delay for sim
    localparam int frameTimeout = 80; // short frame timeout for sim
    localparam int halfBit      = 20; // ck cycles per ps2 clock phase
    localparam int readyWindow  = 10; // max cycles, last rise to wordReady
    localparam int quietCycles  = frameTimeout + 40; // beyond the timeout
    localparam int rowCount     = 26;
    localparam int cycleLimit   = rowCount * frameBits * 40 + 2000;

    // one stimulus row
    typedef struct {
        scanCodeT code;  // byte the device sends
        int       nBits; // 11 full, fewer truncated
        logic     ready; // wordReady expected
    } rowT;

    logic     ck;
    logic     reset;
    logic     ps2Clk;
    logic     ps2Data;
    wire      wordReady;
    scanCodeT scanCode;

    rowT         rowTab[rowCount];
    logic [31:0] lcgState = 32'h53cf4845;
    int          cycleCount = 0;
    int          pulseCount = 0;    // seen by the monitor
    int          expectedPulses = 0; // raised before each full frame

    ps2Receiver #(
        .sampleDelay(sampleDelay),
        .frameTimeout(frameTimeout)
    ) dut_i (
        .ck(ck),
        .reset(reset),
        .ps2Clk(ps2Clk),
        .ps2Data(ps2Data),
        .wordReady(wordReady),
        .scanCode(scanCode)
    );

    ////////////////////////////////////////////////////////////
    // clock, watchdog, pulse monitor
    ////////////////////////////////////////////////////////////

    initial begin
        ck = 1'b0;
        forever #2 ck = ~ck; // 4 ns period
    end

    always @(posedge ck) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the frame table did not finish", cycleCount);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // outputs sampled on the falling edge, away from the drive edge
    always @(negedge ck) begin
        if (!reset && wordReady === 1'b1) begin
            pulseCount = pulseCount + 1;
            if (pulseCount > expectedPulses) begin
                $display("Unexpected wordReady pulse at %0t, no full frame was sent for it",
                         $time);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // numerical recipes constants
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkCode(input string name, input scanCodeT got, input scanCodeT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 8'h%02h, expected 8'h%02h",
                     $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic checkReady(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // device side, start 0, lsb first, odd parity, stop 1
    task automatic sendFrame(input scanCodeT code, input int nBits);
        ps2FrameU    f;
        logic [3:0]  bitIdx;
        f.fields.startBit  = 1'b0;
        f.fields.scanCode  = code;
        f.fields.parityBit = ~^code; // odd count of ones overall
        f.fields.stopBit   = 1'b1;
        @(posedge ck);
        for (int i = 0; i < nBits; i++) begin
            bitIdx = 4'(i);
            ps2Data <= f.raw[bitIdx]; // change while clock high
            repeat (halfBit) @(posedge ck);
            ps2Clk <= 1'b0;           // host samples in this phase
            repeat (halfBit) @(posedge ck);
            ps2Clk <= 1'b1;
        end
        if (nBits < frameBits) begin
            ps2Data <= 1'b1; // truncated, release data, clock stays high
        end
    endtask

    // wordReady must show up soon after the last rising edge
    task automatic waitForReady(input scanCodeT expCode);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < readyWindow) begin
            @(negedge ck);
            waited = waited + 1;
            seen   = wordReady;
        end
        checkReady("wordReady", seen, 1'b1);
        checkCode("scanCode", scanCode, expCode); // valid with the pulse
    endtask

    task automatic checkQuiet(input int cycles);
        repeat (cycles) begin
            @(negedge ck);
            checkReady("wordReady", wordReady, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // frame table
    ////////////////////////////////////////////////////////////

    task automatic fillTable;
        rowTab[0] = '{8'h1c, 11, 1'b1}; // single frame
        rowTab[1] = '{8'hea, 11, 1'b1}; // back to back
        rowTab[2] = '{8'h00, 11, 1'b1};
        rowTab[3] = '{8'hff, 11, 1'b1};
        rowTab[4] = '{8'h5a, 5, 1'b0};  // cut off, then timeout
        rowTab[5] = '{8'h29, 11, 1'b1}; // recovery frame
        for (int r = 6; r < rowCount; r++) begin
            lcgState  = lcgNext(lcgState);
            rowTab[r] = '{lcgState[23:16], 11, 1'b1}; // upper bits mix better
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset   = 1'b1;
        ps2Clk  = 1'b1; // both lines idle high
        ps2Data = 1'b1;
        fillTable();
        repeat (5) @(posedge ck);
        reset <= 1'b0;

        checkQuiet(20); // idle lines, no pulse

        for (int r = 0; r < rowCount; r++) begin
            if (rowTab[r].ready) begin
                expectedPulses = expectedPulses + 1;
            end
            sendFrame(rowTab[r].code, rowTab[r].nBits);
            if (rowTab[r].ready) begin
                waitForReady(rowTab[r].code);
            end else begin
                checkQuiet(quietCycles); // receiver drops the frame
            end
        end

        checkQuiet(20); // no late pulse
        if (pulseCount != expectedPulses) begin
            $display("Pulse count is %0d, but %0d full frames were sent",
                     pulseCount, expectedPulses);
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/ps2Pkg.sv
hdl/ps2BitTimer.sv
hdl/ps2FrameShifter.sv
hdl/ps2RxControl.sv
hdl/ps2Receiver.sv
bench/ps2ReceiverTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ps2ReceiverTb -f compile.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vps2ReceiverTb > sim.log 2>&1
cat sim.log

# the fail message decides, a log without the pass message also fails
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
